// File: source/dbg_pkg.sv
package dbg_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    // one machine word of the 64-bit hart
    typedef logic [63:0] xlen_t;
    // byte address on the debug bus
    typedef logic [14:0] dbg_addr_t;
    // architectural register index
    typedef logic [4:0]  gpr_addr_t;
    // csr number as seen by the csr file
    typedef logic [11:0] csr_addr_t;

    // --------------------------------------------------
    // debug register map
    // --------------------------------------------------
    // always accessible, even with the hart running
    localparam dbg_addr_t DBG_CTRL  = 15'h0000;
    localparam dbg_addr_t DBG_HIT   = 15'h0008;
    localparam dbg_addr_t DBG_IE    = 15'h0010;
    localparam dbg_addr_t DBG_CAUSE = 15'h0018;
    // pc window, kept readable at all times here
    localparam dbg_addr_t DBG_NPC   = 15'h2000;
    localparam dbg_addr_t DBG_PPC   = 15'h2008;

    // --------------------------------------------------
    // register file regions
    // --------------------------------------------------
    // 32 words at stride 8, index in bits 7:3
    localparam dbg_addr_t GPR_BASE  = 15'h0400;
    // 0x4000 up to 0x7fff, csr number in bits 13:2
    localparam dbg_addr_t CSR_BASE  = 15'h4000;

    // --------------------------------------------------
    // control register fields
    // --------------------------------------------------
    // written as halt request, read back as halted flag
    localparam int unsigned CTRL_HALT_BIT = 16;
    // single step enable
    localparam int unsigned CTRL_SS_BIT   = 0;

    // --------------------------------------------------
    // machine csr numbers
    // --------------------------------------------------
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // --------------------------------------------------
    // debug fsm
    // --------------------------------------------------
    typedef enum logic [1:0] {
        DBG_RUNNING,
        DBG_HALT_REQ,
        DBG_SINGLE_STEP,
        DBG_HALTED
    } dbg_state_e;

endpackage

// File: source/dbg_bus_port.sv
module dbg_bus_port import dbg_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // external debug bus
    input  logic      debug_req_i,
    input  logic      debug_we_i,
    input  dbg_addr_t debug_addr_i,
    input  xlen_t     debug_wdata_i,
    output logic      debug_gnt_o,
    output logic      debug_rvalid_o,
    output xlen_t     debug_rdata_o,
    // debug register side
    input  logic      halted_i,
    input  xlen_t     dreg_rdata_i,
    output logic      dreg_we_o,
    output dbg_addr_t dreg_addr_o,
    output xlen_t     dreg_wdata_o,
    // gpr port
    input  xlen_t     gpr_rdata_i,
    output logic      gpr_req_o,
    output logic      gpr_we_o,
    output gpr_addr_t gpr_addr_o,
    output xlen_t     gpr_wdata_o,
    // csr port
    input  xlen_t     csr_rdata_i,
    output logic      csr_req_o,
    output logic      csr_we_o,
    output csr_addr_t csr_addr_o,
    output xlen_t     csr_wdata_o
);

    logic  is_dreg;
    logic  is_gpr;
    logic  is_csr;
    logic  rd_req;
    xlen_t rdata_d;
    xlen_t rdata_q;
    logic  rvalid_q;

    // --------------------------------------------------
    // region decode
    // --------------------------------------------------
    // 0x0000-0x007f and the pc window at 0x2000-0x20ff
    assign is_dreg = (debug_addr_i[14:7] == '0) ||
                     (debug_addr_i[14:8] == DBG_NPC[14:8]);
    // 0x0400-0x04ff, fpr space above it stays unmapped
    assign is_gpr  = (debug_addr_i[14:8] == GPR_BASE[14:8]);
    // upper half of the map
    assign is_csr  = (debug_addr_i[14] == CSR_BASE[14]);

    // no back-pressure, every request granted at once
    assign debug_gnt_o = debug_req_i;
    assign rd_req      = debug_req_i & ~debug_we_i;

    // debug registers take the raw bus fields
    assign dreg_we_o    = debug_req_i & debug_we_i & is_dreg;
    assign dreg_addr_o  = debug_addr_i;
    assign dreg_wdata_o = debug_wdata_i;

    // register files only reachable while halted
    assign gpr_req_o   = debug_req_i & is_gpr & halted_i;
    assign gpr_we_o    = gpr_req_o & debug_we_i;
    assign gpr_addr_o  = debug_addr_i[7:3];
    assign gpr_wdata_o = debug_wdata_i;

    assign csr_req_o   = debug_req_i & is_csr & halted_i;
    assign csr_we_o    = csr_req_o & debug_we_i;
    assign csr_addr_o  = debug_addr_i[13:2];
    assign csr_wdata_o = debug_wdata_i;

    // --------------------------------------------------
    // read data select
    // --------------------------------------------------
    always_comb begin
        // unmapped space and gated files read zero
        rdata_d = '0;
        if (is_dreg) begin
            rdata_d = dreg_rdata_i;
        end else if (gpr_req_o) begin
            rdata_d = gpr_rdata_i;
        end else if (csr_req_o) begin
            rdata_d = csr_rdata_i;
        end
    end

    // response one cycle behind the request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_req;
            // hold last data between reads
            if (rd_req) begin
                rdata_q <= rdata_d;
            end
        end
    end

    assign debug_rvalid_o = rvalid_q;
    assign debug_rdata_o  = rdata_q;

endmodule

// File: source/debug_unit.sv
module debug_unit import dbg_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // register access from the bus port
    input  logic      dreg_we_i,
    input  dbg_addr_t dreg_addr_i,
    input  xlen_t     dreg_wdata_i,
    output xlen_t     dreg_rdata_o,
    // commit and exception stream
    input  logic      commit_valid_i,
    input  logic      commit_ack_i,
    input  xlen_t     commit_pc_i,
    input  logic      ex_valid_i,
    input  xlen_t     ex_cause_i,
    // side band
    input  logic      debug_halt_i,
    input  logic      debug_resume_i,
    output logic      halt_o,
    output logic      halted_o
);

    dbg_state_e state_d, state_q;

    // single step enable and sticky step hit
    logic  ss_d, ss_q;
    logic  hit_d, hit_q;
    // exception enables and recorded cause
    xlen_t ie_d, ie_q;
    xlen_t cause_d, cause_q;
    // pc of the last retired instruction
    xlen_t ppc_q;

    logic  halt_req;
    logic  resume_req;
    logic  ex_hit;
    logic  stepped;

    assign halted_o = (state_q == DBG_HALTED);

    // only enabled causes pull the hart into debug
    assign ex_hit = ex_valid_i & (|(ex_cause_i & ie_q));

    // --------------------------------------------------
    // register writes and requests
    // --------------------------------------------------
    always_comb begin
        ss_d       = ss_q;
        hit_d      = hit_q;
        ie_d       = ie_q;
        cause_d    = cause_q;
        halt_req   = 1'b0;
        resume_req = 1'b0;

        // a finished step sets the sticky bit
        if (stepped) begin
            hit_d = 1'b1;
        end

        // a bus write of the same cycle wins over the step
        if (dreg_we_i) begin
            case (dreg_addr_i)
                DBG_CTRL: begin
                    halt_req   = dreg_wdata_i[CTRL_HALT_BIT];
                    resume_req = ~dreg_wdata_i[CTRL_HALT_BIT];
                    ss_d       = dreg_wdata_i[CTRL_SS_BIT];
                end
                DBG_HIT:   hit_d   = dreg_wdata_i[0];
                DBG_IE:    ie_d    = dreg_wdata_i;
                DBG_CAUSE: cause_d = dreg_wdata_i;
                default:   ;
            endcase
        end

        // enabled exception records its cause and halts
        if (ex_hit) begin
            halt_req = 1'b1;
            cause_d  = ex_cause_i;
        end
    end

    // --------------------------------------------------
    // read mux
    // --------------------------------------------------
    always_comb begin
        dreg_rdata_o = '0;
        case (dreg_addr_i)
            DBG_CTRL: begin
                dreg_rdata_o[CTRL_HALT_BIT] = halted_o;
                dreg_rdata_o[CTRL_SS_BIT]   = ss_q;
            end
            DBG_HIT:   dreg_rdata_o[0] = hit_q;
            DBG_IE:    dreg_rdata_o    = ie_q;
            DBG_CAUSE: dreg_rdata_o    = cause_q;
            // next pc is whatever sits in commit now
            DBG_NPC:   dreg_rdata_o    = commit_pc_i;
            DBG_PPC:   dreg_rdata_o    = ppc_q;
            default:   dreg_rdata_o    = '0;
        endcase
    end

    // --------------------------------------------------
    // halt / step fsm
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        halt_o  = 1'b0;
        stepped = 1'b0;
        case (state_q)
            DBG_RUNNING: begin
                if (halt_req || debug_halt_i) begin
                    state_d = DBG_HALT_REQ;
                end
            end
            // wait for a valid instruction so npc and ppc are meaningful
            DBG_HALT_REQ: begin
                if (commit_valid_i) begin
                    state_d = DBG_HALTED;
                    halt_o  = 1'b1;
                end
            end
            // let exactly one instruction retire
            DBG_SINGLE_STEP: begin
                if (commit_ack_i) begin
                    state_d = DBG_HALT_REQ;
                    stepped = 1'b1;
                end
            end
            DBG_HALTED: begin
                halt_o = 1'b1;
                if (resume_req || debug_resume_i) begin
                    state_d = DBG_RUNNING;
                end
                // stepping wins over a plain resume
                if (ss_q && !hit_q) begin
                    state_d = DBG_SINGLE_STEP;
                end
            end
            default: state_d = DBG_RUNNING;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= DBG_RUNNING;
            ss_q    <= 1'b0;
            hit_q   <= 1'b0;
            ie_q    <= '0;
            cause_q <= '0;
            ppc_q   <= '0;
        end else begin
            state_q <= state_d;
            ss_q    <= ss_d;
            hit_q   <= hit_d;
            ie_q    <= ie_d;
            cause_q <= cause_d;
            // track every retired pc
            if (commit_ack_i) begin
                ppc_q <= commit_pc_i;
            end
        end
    end

endmodule

// File: source/gpr_file.sv
module gpr_file import dbg_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_i,
    input  logic      we_i,
    input  gpr_addr_t addr_i,
    input  xlen_t     wdata_i,
    output xlen_t     rdata_o
);

    // x0 has no storage
    xlen_t regs_q [1:31];
    logic  wr_en;

    // writes to x0 fall through
    assign wr_en = req_i & we_i & (addr_i != '0);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[addr_i] <= wdata_i;
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    // combinational, x0 hardwired zero
    always_comb begin
        if (addr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs_q[addr_i];
        end
    end

endmodule

// File: source/csr_file.sv
module csr_file import dbg_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_i,
    input  logic      we_i,
    input  csr_addr_t addr_i,
    input  xlen_t     wdata_i,
    output xlen_t     rdata_o
);

    // mcause keeps interrupt flag and a 4 bit code
    localparam xlen_t MCAUSE_MASK = {1'b1, 59'b0, 4'hf};

    xlen_t mstatus_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mscratch_q;
    logic  wr_en;

    assign wr_en = req_i & we_i;

    // --------------------------------------------------
    // write side
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mstatus_q  <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (wr_en) begin
            // unknown numbers just drop the write
            case (addr_i)
                CSR_MSTATUS:  mstatus_q  <= wdata_i;
                CSR_MEPC:     mepc_q     <= wdata_i;
                CSR_MCAUSE:   mcause_q   <= wdata_i & MCAUSE_MASK;
                CSR_MSCRATCH: mscratch_q <= wdata_i;
                default:      ;
            endcase
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    always_comb begin
        case (addr_i)
            CSR_MSTATUS:  rdata_o = mstatus_q;
            CSR_MEPC:     rdata_o = mepc_q;
            CSR_MCAUSE:   rdata_o = mcause_q;
            CSR_MSCRATCH: rdata_o = mscratch_q;
            // unimplemented reads zero
            default:      rdata_o = '0;
        endcase
    end

endmodule

// File: source/dbg_subsystem_top.sv
module dbg_subsystem_top import dbg_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // debug bus
    input  logic      debug_req_i,
    input  logic      debug_we_i,
    input  dbg_addr_t debug_addr_i,
    input  xlen_t     debug_wdata_i,
    output logic      debug_gnt_o,
    output logic      debug_rvalid_o,
    output xlen_t     debug_rdata_o,
    // side band
    input  logic      debug_halt_i,
    input  logic      debug_resume_i,
    output logic      debug_halted_o,
    // commit stream
    input  logic      commit_valid_i,
    input  logic      commit_ack_i,
    input  xlen_t     commit_pc_i,
    input  logic      ex_valid_i,
    input  xlen_t     ex_cause_i,
    output logic      halt_o
);

    // --------------------------------------------------
    // internal wires
    // --------------------------------------------------
    logic      halted;
    logic      dreg_we;
    dbg_addr_t dreg_addr;
    xlen_t     dreg_wdata;
    xlen_t     dreg_rdata;

    logic      gpr_req;
    logic      gpr_we;
    gpr_addr_t gpr_addr;
    xlen_t     gpr_wdata;
    xlen_t     gpr_rdata;

    logic      csr_req;
    logic      csr_we;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata;
    xlen_t     csr_rdata;

    assign debug_halted_o = halted;

    // bus front end
    dbg_bus_port i_bus_port (
        .clk_i, .rst_ni,
        .debug_req_i, .debug_we_i, .debug_addr_i, .debug_wdata_i,
        .debug_gnt_o, .debug_rvalid_o, .debug_rdata_o,
        .halted_i     ( halted     ),
        .dreg_rdata_i ( dreg_rdata ),
        .dreg_we_o    ( dreg_we    ),
        .dreg_addr_o  ( dreg_addr  ),
        .dreg_wdata_o ( dreg_wdata ),
        .gpr_rdata_i  ( gpr_rdata  ),
        .gpr_req_o    ( gpr_req    ),
        .gpr_we_o     ( gpr_we     ),
        .gpr_addr_o   ( gpr_addr   ),
        .gpr_wdata_o  ( gpr_wdata  ),
        .csr_rdata_i  ( csr_rdata  ),
        .csr_req_o    ( csr_req    ),
        .csr_we_o     ( csr_we     ),
        .csr_addr_o   ( csr_addr   ),
        .csr_wdata_o  ( csr_wdata  )
    );

    // debug registers and halt control
    debug_unit i_debug_unit (
        .clk_i, .rst_ni,
        .dreg_we_i    ( dreg_we    ),
        .dreg_addr_i  ( dreg_addr  ),
        .dreg_wdata_i ( dreg_wdata ),
        .dreg_rdata_o ( dreg_rdata ),
        .commit_valid_i, .commit_ack_i, .commit_pc_i,
        .ex_valid_i, .ex_cause_i,
        .debug_halt_i, .debug_resume_i,
        .halt_o,
        .halted_o     ( halted     )
    );

    // architectural state
    gpr_file i_gpr_file (
        .clk_i, .rst_ni,
        .req_i   ( gpr_req   ),
        .we_i    ( gpr_we    ),
        .addr_i  ( gpr_addr  ),
        .wdata_i ( gpr_wdata ),
        .rdata_o ( gpr_rdata )
    );

    csr_file i_csr_file (
        .clk_i, .rst_ni,
        .req_i   ( csr_req   ),
        .we_i    ( csr_we    ),
        .addr_i  ( csr_addr  ),
        .wdata_i ( csr_wdata ),
        .rdata_o ( csr_rdata )
    );

endmodule

// File: dv/tb_dbg_subsystem.sv
module tb_dbg_subsystem import dbg_pkg::*; ();

    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] LFSR_SEED  = 32'hc0f5_8ad1;

    typedef enum int {
        OP_READ, OP_READ2, OP_WRITE, OP_HALT, OP_RESUME,
        OP_COMMIT, OP_RETIRE, OP_EXC, OP_FLAG
    } op_e;

    logic      clk_i;
    logic      rst_ni;
    logic      debug_req_i;
    logic      debug_we_i;
    dbg_addr_t debug_addr_i;
    xlen_t     debug_wdata_i;
    logic      debug_gnt_o;
    logic      debug_rvalid_o;
    xlen_t     debug_rdata_o;
    logic      debug_halt_i;
    logic      debug_resume_i;
    logic      debug_halted_o;
    logic      commit_valid_i;
    logic      commit_ack_i;
    xlen_t     commit_pc_i;
    logic      ex_valid_i;
    xlen_t     ex_cause_i;
    logic      halt_o;

    // stimulus table, one entry per index
    string     name_q[$];
    op_e       op_q[$];
    dbg_addr_t addr_q[$];
    xlen_t     data_q[$];
    xlen_t     exp_q[$];
    int        n_entries = 0;
    int        n_errors  = 0;
    logic [31:0] lfsr_state;

    dbg_subsystem_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // random words and address helpers
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    // one lfsr step per bit
    function automatic xlen_t rand_word();
        xlen_t w;
        for (int b = 0; b < 64; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[b] = lfsr_state[0];
        end
        return w;
    endfunction

    function automatic dbg_addr_t gpr_word_addr(input gpr_addr_t idx);
        return GPR_BASE | {7'b0, idx, 3'b000};
    endfunction

    function automatic dbg_addr_t csr_word_addr(input csr_addr_t num);
        return CSR_BASE | {1'b0, num, 2'b00};
    endfunction

    // --------------------------------------------------
    // error handling and compares
    // --------------------------------------------------
    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string what);
        n_errors++;
        $display("ERROR: %s", what);
        stop_run();
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_state(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // bus and commit drivers
    // --------------------------------------------------
    task automatic bus_write(input string name, input dbg_addr_t a, input xlen_t d);
        @(posedge clk_i);
        debug_req_i   <= 1'b1;
        debug_we_i    <= 1'b1;
        debug_addr_i  <= a;
        debug_wdata_i <= d;
        @(negedge clk_i);
        if (debug_gnt_o !== 1'b1) report_error({"write not granted in ", name});
        @(posedge clk_i);
        debug_req_i <= 1'b0;
        debug_we_i  <= 1'b0;
        // a write gets no response
        @(negedge clk_i);
        if (debug_rvalid_o !== 1'b0) report_error({"rvalid raised after write in ", name});
    endtask

    // pair keeps the request up two cycles so responses overlap the next request
    task automatic bus_read(input string name, input dbg_addr_t a, input xlen_t exp,
                            input bit pair);
        @(posedge clk_i);
        debug_req_i  <= 1'b1;
        debug_we_i   <= 1'b0;
        debug_addr_i <= a;
        @(negedge clk_i);
        if (debug_gnt_o !== 1'b1) report_error({"read not granted in ", name});
        if (pair) begin
            @(negedge clk_i);
            if (debug_gnt_o !== 1'b1) report_error({"second read not granted in ", name});
            if (debug_rvalid_o !== 1'b1) report_error({"no rvalid for first read in ", name});
            check_xlen(name, exp, debug_rdata_o);
        end
        @(posedge clk_i);
        debug_req_i <= 1'b0;
        @(negedge clk_i);
        if (debug_rvalid_o !== 1'b1) report_error({"no rvalid after read in ", name});
        check_xlen(name, exp, debug_rdata_o);
    endtask

    task automatic drive_commit(input xlen_t pc, input logic ack);
        @(posedge clk_i);
        commit_valid_i <= 1'b1;
        commit_ack_i   <= ack;
        commit_pc_i    <= pc;
        @(posedge clk_i);
        // pc stays on the port so npc keeps a known value
        commit_valid_i <= 1'b0;
        commit_ack_i   <= 1'b0;
    endtask

    task automatic apply_entry(input int i);
        xlen_t d;
        d = data_q[i];
        case (op_q[i])
            OP_WRITE:  bus_write(name_q[i], addr_q[i], d);
            OP_READ:   bus_read(name_q[i], addr_q[i], exp_q[i], 1'b0);
            OP_READ2:  bus_read(name_q[i], addr_q[i], exp_q[i], 1'b1);
            OP_COMMIT: drive_commit(d, 1'b0);
            OP_RETIRE: drive_commit(d, 1'b1);
            OP_HALT: begin
                @(posedge clk_i) debug_halt_i <= 1'b1;
                @(posedge clk_i) debug_halt_i <= 1'b0;
            end
            OP_RESUME: begin
                @(posedge clk_i) debug_resume_i <= 1'b1;
                @(posedge clk_i) debug_resume_i <= 1'b0;
            end
            OP_EXC: begin
                @(posedge clk_i);
                ex_valid_i <= 1'b1;
                ex_cause_i <= d;
                @(posedge clk_i) ex_valid_i <= 1'b0;
            end
            // one more edge so the fsm settles before sampling
            OP_FLAG: begin
                @(posedge clk_i);
                @(negedge clk_i);
                check_state({name_q[i], " halted"}, exp_q[i][0], debug_halted_o);
                check_state({name_q[i], " halt_o"}, exp_q[i][0], halt_o);
            end
            default: report_error("unknown table operation");
        endcase
    endtask

    // --------------------------------------------------
    // table with model expectations
    // --------------------------------------------------
    task automatic add_entry(input string name, input op_e op, input dbg_addr_t a,
                             input xlen_t d, input xlen_t exp);
        name_q.push_back(name);
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(exp);
    endtask

    task automatic build_table();
        xlen_t ie_w, cause_w, hit_w, w;
        xlen_t pc_a, pc_b;
        lfsr_state = LFSR_SEED;
        // running, debug registers always reachable
        ie_w    = rand_word();
        cause_w = rand_word();
        // bit 0 set so the sticky bit really moves
        hit_w   = rand_word() | 64'd1;
        add_entry("ie write", OP_WRITE, DBG_IE, ie_w, '0);
        add_entry("ie read", OP_READ, DBG_IE, '0, ie_w);
        add_entry("ie back to back", OP_READ2, DBG_IE, '0, ie_w);
        add_entry("cause write", OP_WRITE, DBG_CAUSE, cause_w, '0);
        add_entry("cause read", OP_READ, DBG_CAUSE, '0, cause_w);
        add_entry("hit write", OP_WRITE, DBG_HIT, hit_w, '0);
        add_entry("hit read", OP_READ, DBG_HIT, '0, {63'b0, hit_w[0]});
        add_entry("hit clear", OP_WRITE, DBG_HIT, '0, '0);
        add_entry("hit cleared", OP_READ, DBG_HIT, '0, '0);
        add_entry("ctrl running", OP_READ, DBG_CTRL, '0, '0);
        // register files gated while running
        add_entry("gpr gated write", OP_WRITE, gpr_word_addr(5), rand_word(), '0);
        add_entry("gpr gated read", OP_READ, gpr_word_addr(5), '0, '0);
        add_entry("csr gated write", OP_WRITE, csr_word_addr(CSR_MSCRATCH), rand_word(), '0);
        add_entry("csr gated read", OP_READ, csr_word_addr(CSR_MSCRATCH), '0, '0);
        // side band halt, ppc from the retired pc, npc live
        pc_a = rand_word();
        pc_b = rand_word();
        add_entry("retire running", OP_RETIRE, '0, pc_a, '0);
        add_entry("halt pulse", OP_HALT, '0, '0, '0);
        add_entry("halt commit", OP_COMMIT, '0, pc_b, '0);
        add_entry("halt entered", OP_FLAG, '0, '0, 64'd1);
        add_entry("ctrl halted", OP_READ, DBG_CTRL, '0, 64'h1_0000);
        add_entry("npc live", OP_READ, DBG_NPC, '0, pc_b);
        add_entry("ppc retired", OP_READ, DBG_PPC, '0, pc_a);
        add_entry("gpr write dropped", OP_READ, gpr_word_addr(5), '0, '0);
        add_entry("csr write dropped", OP_READ, csr_word_addr(CSR_MSCRATCH), '0, '0);
        // halted register file access
        w = rand_word();
        add_entry("gpr write", OP_WRITE, gpr_word_addr(7), w, '0);
        add_entry("gpr read", OP_READ, gpr_word_addr(7), '0, w);
        w = rand_word();
        add_entry("gpr x31 write", OP_WRITE, gpr_word_addr(31), w, '0);
        add_entry("gpr x31 read", OP_READ, gpr_word_addr(31), '0, w);
        add_entry("x0 write", OP_WRITE, gpr_word_addr(0), rand_word(), '0);
        add_entry("x0 read", OP_READ, gpr_word_addr(0), '0, '0);
        w = rand_word();
        add_entry("mscratch write", OP_WRITE, csr_word_addr(CSR_MSCRATCH), w, '0);
        add_entry("mscratch read", OP_READ, csr_word_addr(CSR_MSCRATCH), '0, w);
        w = rand_word();
        add_entry("mepc write", OP_WRITE, csr_word_addr(CSR_MEPC), w, '0);
        add_entry("mepc read", OP_READ, csr_word_addr(CSR_MEPC), '0, w);
        w = rand_word();
        // sign bit and low four bits survive
        add_entry("mcause write", OP_WRITE, csr_word_addr(CSR_MCAUSE), w, '0);
        add_entry("mcause read", OP_READ, csr_word_addr(CSR_MCAUSE), '0,
                  w & 64'h8000_0000_0000_000f);
        add_entry("csr unimpl write", OP_WRITE, csr_word_addr(12'h7c0), rand_word(), '0);
        add_entry("csr unimpl read", OP_READ, csr_word_addr(12'h7c0), '0, '0);
        add_entry("fpr space read", OP_READ, 15'h0500, '0, '0);
        // single step twice, the second after clearing hit
        pc_a = rand_word();
        add_entry("step enable", OP_WRITE, DBG_CTRL, 64'h1_0001, '0);
        add_entry("step running", OP_FLAG, '0, '0, '0);
        add_entry("step retire", OP_RETIRE, '0, pc_a, '0);
        add_entry("step commit", OP_COMMIT, '0, rand_word(), '0);
        add_entry("step halted", OP_FLAG, '0, '0, 64'd1);
        add_entry("ctrl stepping", OP_READ, DBG_CTRL, '0, 64'h1_0001);
        add_entry("hit after step", OP_READ, DBG_HIT, '0, 64'd1);
        add_entry("ppc after step", OP_READ, DBG_PPC, '0, pc_a);
        add_entry("hit clear step", OP_WRITE, DBG_HIT, '0, '0);
        add_entry("second step", OP_FLAG, '0, '0, '0);
        add_entry("second retire", OP_RETIRE, '0, rand_word(), '0);
        add_entry("second commit", OP_COMMIT, '0, rand_word(), '0);
        add_entry("second halted", OP_FLAG, '0, '0, 64'd1);
        add_entry("hit after second", OP_READ, DBG_HIT, '0, 64'd1);
        add_entry("ctrl resume", OP_WRITE, DBG_CTRL, '0, '0);
        add_entry("ctrl resumed", OP_FLAG, '0, '0, '0);
        // x7 and mscratch hold data now, still read zero while running
        add_entry("gpr gated nonzero", OP_READ, gpr_word_addr(7), '0, '0);
        add_entry("csr gated nonzero", OP_READ, csr_word_addr(CSR_MSCRATCH), '0, '0);
        // exceptions, masked cause first
        ie_w = rand_word() | 64'd1;
        hit_w = (rand_word() & ie_w) | 64'd1;
        add_entry("ie exc write", OP_WRITE, DBG_IE, ie_w, '0);
        add_entry("exc masked", OP_EXC, '0, ~ie_w, '0);
        add_entry("exc masked commit", OP_COMMIT, '0, rand_word(), '0);
        add_entry("exc masked running", OP_FLAG, '0, '0, '0);
        add_entry("cause kept", OP_READ, DBG_CAUSE, '0, cause_w);
        add_entry("exc enabled", OP_EXC, '0, hit_w, '0);
        add_entry("exc commit", OP_COMMIT, '0, rand_word(), '0);
        add_entry("exc halted", OP_FLAG, '0, '0, 64'd1);
        add_entry("cause recorded", OP_READ, DBG_CAUSE, '0, hit_w);
        add_entry("resume pulse", OP_RESUME, '0, '0, '0);
        add_entry("pulse resumed", OP_FLAG, '0, '0, '0);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        rst_ni         = 1'b0;
        debug_req_i    = 1'b0;
        debug_we_i     = 1'b0;
        debug_addr_i   = '0;
        debug_wdata_i  = '0;
        debug_halt_i   = 1'b0;
        debug_resume_i = 1'b0;
        commit_valid_i = 1'b0;
        commit_ack_i   = 1'b0;
        commit_pc_i    = '0;
        ex_valid_i     = 1'b0;
        ex_cause_i     = '0;
        build_table();
        n_entries = name_q.size();
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_state("reset rvalid", 1'b0, debug_rvalid_o);
        check_state("reset halted", 1'b0, debug_halted_o);
        check_state("reset halt_o", 1'b0, halt_o);
        for (int i = 0; i < n_entries; i++) begin
            apply_entry(i);
        end
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, 40 cycles per entry plus reset
    initial begin
        wait (n_entries != 0);
        repeat ((n_entries + 8) * 40) @(posedge clk_i);
        $display("timeout: the table did not finish in time");
        stop_run();
    end

endmodule

// File: filelist.f
source/dbg_pkg.sv
source/dbg_bus_port.sv
source/debug_unit.sv
source/gpr_file.sv
source/csr_file.sv
source/dbg_subsystem_top.sv
dv/tb_dbg_subsystem.sv

// File: Bender.yml
package:
  name: dbg_subsystem

sources:
  # package first, then the blocks, then the top level
  - source/dbg_pkg.sv
  - source/dbg_bus_port.sv
  - source/debug_unit.sv
  - source/gpr_file.sv
  - source/csr_file.sv
  - source/dbg_subsystem_top.sv

  # testbench only in simulation
  - target: test
    files:
      - dv/tb_dbg_subsystem.sv
